// ==== build.f ====
+incdir+include
src/wb_xbar_pkg.sv
src/wb_master_port.sv
src/wb_rr_arbiter.sv
src/wb_target_router.sv
src/wb_xbar_top.sv
tests/wb_xbar_mem_model.sv
tests/wb_xbar_chk.sv
tests/wb_xbar_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= wb_xbar_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/wb_xbar_tb.sv ====
// Top-level testbench of the 3x4 Wishbone crossbar that runs a per-master stimulus table against memory models
`include "wb_xbar_params.svh"

module wb_xbar_tb import wb_xbar_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_MST = `WB_N_MASTERS;
	localparam int N_SLV = `WB_N_SLAVES;
	localparam int MAX_ROWS = 64;
	localparam int CYCLES_PER_ROW = 40;

	logic clk = 1'b0;
	logic rstn;

	// Master side
	logic m_cyc [N_MST];
	logic m_stb [N_MST];
	logic m_we [N_MST];
	wb_adr_t m_adr [N_MST];
	wb_sel_t m_sel [N_MST];
	wb_dat_t m_wdat [N_MST];
	logic m_ack [N_MST];
	logic m_err [N_MST];
	wb_dat_t m_rdat [N_MST];

	// Slave side
	logic s_cyc [N_SLV];
	logic s_stb [N_SLV];
	logic s_we [N_SLV];
	wb_adr_t s_adr [N_SLV];
	wb_sel_t s_sel [N_SLV];
	wb_dat_t s_wdat [N_SLV];
	logic s_ack [N_SLV];
	logic s_err [N_SLV];
	wb_dat_t s_rdat [N_SLV];

	// Stimulus table with one row per transaction
	int row_master [MAX_ROWS];
	wb_adr_t row_adr [MAX_ROWS];
	logic row_we [MAX_ROWS];
	wb_sel_t row_sel [MAX_ROWS];
	wb_dat_t row_wdat [MAX_ROWS];
	wb_dat_t row_exp_dat [MAX_ROWS];
	logic row_exp_err [MAX_ROWS];
	string row_name [MAX_ROWS];
	int n_rows = 0;

	int errors;
	int checks;
	int want_rows [N_MST];
	int done_rows [N_MST];

	// 8 ns period
	always #4 clk = ~clk;

	wb_xbar_top wb_xbar_top_i (
		.clk(clk),
		.rstn(rstn),
		.m_cyc_i(m_cyc),
		.m_stb_i(m_stb),
		.m_we_i(m_we),
		.m_adr_i(m_adr),
		.m_sel_i(m_sel),
		.m_dat_i(m_wdat),
		.m_ack_o(m_ack),
		.m_err_o(m_err),
		.m_dat_o(m_rdat),
		.s_cyc_o(s_cyc),
		.s_stb_o(s_stb),
		.s_we_o(s_we),
		.s_adr_o(s_adr),
		.s_sel_o(s_sel),
		.s_dat_o(s_wdat),
		.s_ack_i(s_ack),
		.s_err_i(s_err),
		.s_dat_i(s_rdat)
	);

	// One 64-word memory per slave port
	for (genvar s = 0; s < N_SLV; s++) begin : g_mem
		wb_xbar_mem_model #(
			.DEPTH(64),
			.MAX_WAIT(3)
		) wb_xbar_mem_model_i (
			.clk(clk),
			.rstn(rstn),
			.cyc_i(s_cyc[s]),
			.stb_i(s_stb[s]),
			.we_i(s_we[s]),
			.adr_i(s_adr[s]),
			.sel_i(s_sel[s]),
			.dat_i(s_wdat[s]),
			.ack_o(s_ack[s]),
			.err_o(s_err[s]),
			.dat_o(s_rdat[s])
		);
	end

	// Inclusive window bounds of each slave
	function automatic wb_adr_t window_lo(input int s);
		case (s)
			0: return `WB_S0_BASE;
			1: return `WB_S1_BASE;
			2: return `WB_S2_BASE;
			default: return `WB_S3_BASE;
		endcase
	endfunction

	function automatic wb_adr_t window_hi(input int s);
		case (s)
			0: return `WB_S0_LIMIT;
			1: return `WB_S1_LIMIT;
			2: return `WB_S2_LIMIT;
			default: return `WB_S3_LIMIT;
		endcase
	endfunction

	// Selected bytes come from the new word and the others keep their old value
	function automatic wb_dat_t merge_bytes(input wb_dat_t old_w, input wb_dat_t new_w,
			input wb_sel_t sel);
		wb_dat_t res;
		res = old_w;
		for (int b = 0; b < $bits(wb_sel_t); b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic compare_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic add_row(input int m, input wb_adr_t adr, input logic we, input wb_sel_t sel,
			input wb_dat_t wdat, input wb_dat_t exp_dat, input logic exp_err, input string name);
		row_master[n_rows] = m;
		row_adr[n_rows] = adr;
		row_we[n_rows] = we;
		row_sel[n_rows] = sel;
		row_wdat[n_rows] = wdat;
		row_exp_dat[n_rows] = exp_dat;
		row_exp_err[n_rows] = exp_err;
		row_name[n_rows] = name;
		want_rows[m]++;
		n_rows++;
	endtask

	// Each master owns a 16-byte slot in every window so that results do not depend on order
	task automatic build_table();
		wb_dat_t word [N_MST][N_SLV];
		wb_dat_t part;
		wb_adr_t a;
		for (int m = 0; m < N_MST; m++) begin
			for (int s = 0; s < N_SLV; s++) begin
				word[m][s] = $urandom();
				a = window_lo(s) + wb_adr_t'(16 * m);
				add_row(m, a, 1'b1, 4'hF, word[m][s], '0, 1'b0, $sformatf("m%0d_wr_s%0d", m, s));
			end
		end
		for (int m = 0; m < N_MST; m++) begin
			for (int s = 0; s < N_SLV; s++) begin
				a = window_lo(s) + wb_adr_t'(16 * m);
				add_row(m, a, 1'b0, 4'hF, '0, word[m][s], 1'b0, $sformatf("m%0d_rd_s%0d", m, s));
			end
		end
		// Low half write into the slave 0 word
		for (int m = 0; m < N_MST; m++) begin
			part = $urandom();
			a = window_lo(0) + wb_adr_t'(16 * m);
			add_row(m, a, 1'b1, 4'b0011, part, '0, 1'b0, $sformatf("m%0d_wr_half", m));
			add_row(m, a, 1'b0, 4'hF, '0, merge_bytes(word[m][0], part, 4'b0011), 1'b0,
				$sformatf("m%0d_rd_half", m));
		end
		// Holes in the map end in ERR with zero data
		for (int m = 0; m < N_MST; m++) begin
			add_row(m, 32'h0000_2000, 1'b0, 4'hF, '0, '0, 1'b1, $sformatf("m%0d_rd_hole", m));
			add_row(m, 32'hFFFF_FFF0, 1'b1, 4'hF, 32'hDEAD_BEEF, '0, 1'b1,
				$sformatf("m%0d_wr_top", m));
			add_row(m, 32'hFFFF_FFF0, 1'b0, 4'hF, '0, '0, 1'b1, $sformatf("m%0d_rd_top", m));
		end
	endtask

	// One classic cycle with the response sampled on the falling edge
	task automatic do_transfer(input int r);
		int m;
		logic got_err;
		wb_dat_t got_dat;
		m = row_master[r];
		@(posedge clk);
		m_cyc[m] <= 1'b1;
		m_stb[m] <= 1'b1;
		m_we[m] <= row_we[r];
		m_adr[m] <= row_adr[r];
		m_sel[m] <= row_sel[r];
		m_wdat[m] <= row_wdat[r];
		do begin
			@(negedge clk);
		end while (!(m_ack[m] || m_err[m]));
		got_err = m_err[m];
		got_dat = m_rdat[m];
		// Strobe drops on the edge after the response
		@(posedge clk);
		m_cyc[m] <= 1'b0;
		m_stb[m] <= 1'b0;
		m_we[m] <= 1'b0;
		compare_flag({row_name[r], "_err"}, row_exp_err[r], got_err);
		if (!row_we[r] || row_exp_err[r]) begin
			compare_dat({row_name[r], "_dat"}, row_exp_dat[r], got_dat);
		end
	endtask

	task automatic run_master(input int m);
		for (int r = 0; r < n_rows; r++) begin
			if (row_master[r] == m) begin
				do_transfer(r);
				done_rows[m]++;
			end
		end
	endtask

	task automatic check_reset_state(input string tag);
		for (int m = 0; m < N_MST; m++) begin
			compare_flag($sformatf("%s_m%0d_ack", tag, m), 1'b0, m_ack[m]);
			compare_flag($sformatf("%s_m%0d_err", tag, m), 1'b0, m_err[m]);
		end
		for (int s = 0; s < N_SLV; s++) begin
			compare_flag($sformatf("%s_s%0d_cyc", tag, s), 1'b0, s_cyc[s]);
			compare_flag($sformatf("%s_s%0d_stb", tag, s), 1'b0, s_stb[s]);
		end
	endtask

	// A slave strobe must carry an address inside that slave's window
	always @(negedge clk) begin
		if (rstn === 1'b1) begin
			for (int s = 0; s < N_SLV; s++) begin
				if (s_stb[s] && (s_adr[s] < window_lo(s) || s_adr[s] > window_hi(s))) begin
					errors++;
					$display("Slave %0d saw a strobe at address %h outside its window",
						s, s_adr[s]);
				end
			end
		end
	end

	// Watchdog scaled by the table length
	initial begin
		wait (n_rows > 0);
		repeat (n_rows * CYCLES_PER_ROW) @(posedge clk);
		$display("Watchdog expired after %0d cycles with transactions still open",
			n_rows * CYCLES_PER_ROW);
		// Progress of each master shows which one starved
		for (int m = 0; m < N_MST; m++) begin
			$display("Master %0d finished only %0d of %0d transactions",
				m, done_rows[m], want_rows[m]);
		end
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h741c_995d));
		errors = 0;
		checks = 0;
		rstn = 1'b0;
		for (int m = 0; m < N_MST; m++) begin
			m_cyc[m] = 1'b0;
			m_stb[m] = 1'b0;
			m_we[m] = 1'b0;
			m_adr[m] = '0;
			m_sel[m] = '0;
			m_wdat[m] = '0;
			want_rows[m] = 0;
			done_rows[m] = 0;
		end
		build_table();

		// Two edges in reset before release
		@(posedge clk);
		@(negedge clk);
		check_reset_state("in_reset");
		@(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
		check_reset_state("after_reset");

		// Masters run at once and their first rows all hit slave 0
		fork
			run_master(0);
			run_master(1);
			run_master(2);
		join

		repeat (4) @(posedge clk);
		$display("Rows %0d, checks %0d, errors %0d", n_rows, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tests/wb_xbar_chk.sv ====
// Protocol assertions for the crossbar, attached to the top level by the bind at the end
`include "wb_xbar_params.svh"

module wb_xbar_chk (
	input logic clk,
	input logic rstn,
	input logic m_cyc_i [`WB_N_MASTERS],
	input logic m_ack_o [`WB_N_MASTERS],
	input logic m_err_o [`WB_N_MASTERS],
	input logic s_cyc_o [`WB_N_SLAVES],
	input logic s_stb_o [`WB_N_SLAVES]
);
	timeunit 1ns;
	timeprecision 1ps;

	for (genvar m = 0; m < `WB_N_MASTERS; m++) begin : g_mst
		// A response is an ACK or an ERR, never both
		a_rsp_onehot: assert property (@(posedge clk) disable iff (!rstn)
			!(m_ack_o[m] && m_err_o[m]))
			else $error("Master %0d sees ACK and ERR in the same cycle", m);

		// Responses only inside the master's own cycle
		a_rsp_in_cyc: assert property (@(posedge clk) disable iff (!rstn)
			(m_ack_o[m] || m_err_o[m]) |-> m_cyc_i[m])
			else $error("Master %0d gets a response without CYC", m);
	end

	for (genvar s = 0; s < `WB_N_SLAVES; s++) begin : g_slv
		// Router never strobes outside a cycle
		a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rstn)
			s_stb_o[s] |-> s_cyc_o[s])
			else $error("Slave %0d sees STB without CYC", s);
	end

endmodule

bind wb_xbar_top wb_xbar_chk wb_xbar_chk_i (
	.clk(clk),
	.rstn(rstn),
	.m_cyc_i(m_cyc_i),
	.m_ack_o(m_ack_o),
	.m_err_o(m_err_o),
	.s_cyc_o(s_cyc_o),
	.s_stb_o(s_stb_o)
);

// ==== tests/wb_xbar_mem_model.sv ====
// Behavioral Wishbone slave memory for the crossbar testbench, one instance on each slave port
module wb_xbar_mem_model import wb_xbar_pkg::*; #(
	parameter int DEPTH = 64,
	parameter int MAX_WAIT = 3
) (
	input logic clk,
	input logic rstn,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input wb_adr_t adr_i,
	input wb_sel_t sel_i,
	input wb_dat_t dat_i,
	output logic ack_o,
	output logic err_o,
	output wb_dat_t dat_o
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int AW = $clog2(DEPTH);

	wb_dat_t mem [DEPTH];
	logic [AW-1:0] idx;
	// Wait states still owed to the access in progress
	int unsigned wait_q;
	logic busy_q;
	int unsigned d;

	// Word index, byte offset dropped
	assign idx = adr_i[AW+1:2];

	// Memory never signals an error
	assign err_o = 1'b0;

	always @(posedge clk) begin
		if (!rstn) begin
			ack_o <= 1'b0;
			busy_q <= 1'b0;
			wait_q <= 0;
			dat_o <= '0;
		end else if (ack_o) begin
			// Single-cycle ACK, master drops STB on this edge
			ack_o <= 1'b0;
			busy_q <= 1'b0;
		end else if (cyc_i && stb_i) begin
			// New access draws its wait states, a pending one counts down
			d = busy_q ? wait_q : $urandom_range(MAX_WAIT, 0);
			if (d == 0) begin
				ack_o <= 1'b1;
				busy_q <= 1'b0;
				dat_o <= we_i ? '0 : mem[idx];
				if (we_i) begin
					for (int b = 0; b < $bits(wb_sel_t); b++) begin
						if (sel_i[b]) begin
							mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
						end
					end
				end
			end else begin
				busy_q <= 1'b1;
				wait_q <= d - 1;
			end
		end
	end

endmodule

// ==== src/wb_xbar_top.sv ====
// Top of the 3x4 Wishbone classic crossbar, connects master ports, target arbiters and router
`include "wb_xbar_params.svh"

module wb_xbar_top import wb_xbar_pkg::*; (
	input logic clk,
	input logic rstn,
	// Master side
	input logic m_cyc_i [`WB_N_MASTERS],
	input logic m_stb_i [`WB_N_MASTERS],
	input logic m_we_i [`WB_N_MASTERS],
	input wb_adr_t m_adr_i [`WB_N_MASTERS],
	input wb_sel_t m_sel_i [`WB_N_MASTERS],
	input wb_dat_t m_dat_i [`WB_N_MASTERS],
	output logic m_ack_o [`WB_N_MASTERS],
	output logic m_err_o [`WB_N_MASTERS],
	output wb_dat_t m_dat_o [`WB_N_MASTERS],
	// Slave side
	output logic s_cyc_o [`WB_N_SLAVES],
	output logic s_stb_o [`WB_N_SLAVES],
	output logic s_we_o [`WB_N_SLAVES],
	output wb_adr_t s_adr_o [`WB_N_SLAVES],
	output wb_sel_t s_sel_o [`WB_N_SLAVES],
	output wb_dat_t s_dat_o [`WB_N_SLAVES],
	input logic s_ack_i [`WB_N_SLAVES],
	input logic s_err_i [`WB_N_SLAVES],
	input wb_dat_t s_dat_i [`WB_N_SLAVES]
);

	localparam int N_MST = `WB_N_MASTERS;
	localparam int N_TGT = `WB_N_SLAVES + 1;

	// Registered target of each master
	target_id_t port_target [N_MST];
	logic port_valid [N_MST];

	// Request vector of each target, one bit per master
	logic [N_MST-1:0] tgt_req [N_TGT];

	// Arbitration result of each target
	logic [N_TGT-1:0] tgt_gnt;
	master_id_t tgt_gnt_id [N_TGT];

	// Target responses, error responder in the last slot
	logic [N_TGT-1:0] tgt_ack;
	logic [N_TGT-1:0] tgt_err;
	wb_dat_t tgt_dat [N_TGT];

	// One tracker per master
	for (genvar m = 0; m < N_MST; m++) begin : g_port
		wb_master_port #(
			.MASTER_ID(master_id_t'(m))
		) wb_master_port_i (
			.clk(clk),
			.rstn(rstn),
			.cyc_i(m_cyc_i[m]),
			.stb_i(m_stb_i[m]),
			.adr_i(m_adr_i[m]),
			.gnt_i(tgt_gnt),
			.gnt_id_i(tgt_gnt_id),
			.s_ack_i(tgt_ack),
			.s_err_i(tgt_err),
			.s_dat_i(tgt_dat),
			.target_o(port_target[m]),
			.valid_o(port_valid[m]),
			.ack_o(m_ack_o[m]),
			.err_o(m_err_o[m]),
			.dat_o(m_dat_o[m])
		);
	end

	// A master requests a target while its tracker holds that index
	for (genvar t = 0; t < N_TGT; t++) begin : g_req
		for (genvar m = 0; m < N_MST; m++) begin : g_mst
			assign tgt_req[t][m] = port_valid[m] && (port_target[m] == target_id_t'(t));
		end
	end

	// Independent arbiter per target, so a stalled slave holds up only its own requesters
	for (genvar t = 0; t < N_TGT; t++) begin : g_arb
		wb_rr_arbiter #(
			.N_REQ(N_MST)
		) wb_rr_arbiter_i (
			.clk(clk),
			.rstn(rstn),
			.req_i(tgt_req[t]),
			.gnt_o(tgt_gnt[t]),
			.gnt_id_o(tgt_gnt_id[t])
		);
	end

	// Request steering and the decode-error responder
	wb_target_router wb_target_router_i (
		.clk(clk),
		.rstn(rstn),
		.m_cyc_i(m_cyc_i),
		.m_stb_i(m_stb_i),
		.m_we_i(m_we_i),
		.m_adr_i(m_adr_i),
		.m_sel_i(m_sel_i),
		.m_dat_i(m_dat_i),
		.gnt_i(tgt_gnt),
		.gnt_id_i(tgt_gnt_id),
		.s_ack_i(s_ack_i),
		.s_err_i(s_err_i),
		.s_dat_i(s_dat_i),
		.s_cyc_o(s_cyc_o),
		.s_stb_o(s_stb_o),
		.s_we_o(s_we_o),
		.s_adr_o(s_adr_o),
		.s_sel_o(s_sel_o),
		.s_dat_o(s_dat_o),
		.ack_o(tgt_ack),
		.err_o(tgt_err),
		.dat_o(tgt_dat)
	);

endmodule

// ==== src/wb_target_router.sv ====
// Crossbar request router, steers each granted master to its target and holds the decode-error responder
`include "wb_xbar_params.svh"

module wb_target_router import wb_xbar_pkg::*; (
	input logic clk,
	input logic rstn,
	// Master requests
	input logic m_cyc_i [`WB_N_MASTERS],
	input logic m_stb_i [`WB_N_MASTERS],
	input logic m_we_i [`WB_N_MASTERS],
	input wb_adr_t m_adr_i [`WB_N_MASTERS],
	input wb_sel_t m_sel_i [`WB_N_MASTERS],
	input wb_dat_t m_dat_i [`WB_N_MASTERS],
	// Grant of each target, slaves and error responder
	input logic [`WB_N_SLAVES:0] gnt_i,
	input master_id_t gnt_id_i [`WB_N_SLAVES+1],
	// External slave side
	input logic s_ack_i [`WB_N_SLAVES],
	input logic s_err_i [`WB_N_SLAVES],
	input wb_dat_t s_dat_i [`WB_N_SLAVES],
	output logic s_cyc_o [`WB_N_SLAVES],
	output logic s_stb_o [`WB_N_SLAVES],
	output logic s_we_o [`WB_N_SLAVES],
	output wb_adr_t s_adr_o [`WB_N_SLAVES],
	output wb_sel_t s_sel_o [`WB_N_SLAVES],
	output wb_dat_t s_dat_o [`WB_N_SLAVES],
	// Responses of all targets towards the master ports
	output logic [`WB_N_SLAVES:0] ack_o,
	output logic [`WB_N_SLAVES:0] err_o,
	output wb_dat_t dat_o [`WB_N_SLAVES+1]
);

	localparam int N_TGT = `WB_N_SLAVES + 1;

	// Strobes of every target, error slot included
	logic t_cyc [N_TGT];
	logic t_stb [N_TGT];

	// Decode-error responder state
	logic err_q;
	logic err_stb;

	// Cycle and strobe follow the owner, zero while the target is free
	for (genvar t = 0; t < N_TGT; t++) begin : g_strobe
		assign t_cyc[t] = gnt_i[t] ? m_cyc_i[gnt_id_i[t]] : 1'b0;
		assign t_stb[t] = gnt_i[t] ? m_stb_i[gnt_id_i[t]] : 1'b0;
	end

	// External slaves get the full request of their owner
	for (genvar s = 0; s < `WB_N_SLAVES; s++) begin : g_slave
		assign s_cyc_o[s] = t_cyc[s];
		assign s_stb_o[s] = t_stb[s];
		assign s_we_o[s] = gnt_i[s] ? m_we_i[gnt_id_i[s]] : 1'b0;
		assign s_adr_o[s] = gnt_i[s] ? m_adr_i[gnt_id_i[s]] : '0;
		assign s_sel_o[s] = gnt_i[s] ? m_sel_i[gnt_id_i[s]] : '0;
		assign s_dat_o[s] = gnt_i[s] ? m_dat_i[gnt_id_i[s]] : '0;

		// Slave answers go back unchanged, the master port picks its own
		assign ack_o[s] = s_ack_i[s];
		assign err_o[s] = s_err_i[s];
		assign dat_o[s] = s_dat_i[s];
	end

	// Error responder sees only a live strobe
	assign err_stb = t_cyc[TARGET_ERR] && t_stb[TARGET_ERR];

	// ERR one cycle after the strobe, for one cycle
	// The held strobe in the response cycle does not retrigger it
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= err_stb && !err_q;
		end
	end

	// Never ACKs, read data reads as zero
	assign ack_o[TARGET_ERR] = 1'b0;
	assign err_o[TARGET_ERR] = err_q;
	assign dat_o[TARGET_ERR] = '0;

endmodule

// ==== src/wb_rr_arbiter.sv ====
// Round-robin arbiter for one crossbar target, grant is registered and held while its owner requests
module wb_rr_arbiter import wb_xbar_pkg::*; #(
	parameter int N_REQ = 3
) (
	input logic clk,
	input logic rstn,
	input logic [N_REQ-1:0] req_i,
	output logic gnt_o,
	output master_id_t gnt_id_o
);

	// Current one-hot grant, zero while the target is free
	logic [N_REQ-1:0] gnt_q;
	// Most recent one-hot grant, kept after release to rotate priority
	logic [N_REQ-1:0] last_gnt_q;
	master_id_t gnt_id_q;

	// Requesters strictly above the last grant
	logic [N_REQ-1:0] above;
	logic [N_REQ-1:0] masked_req;
	logic [N_REQ-1:0] pick;

	// Isolate the lowest set bit
	function automatic logic [N_REQ-1:0] lowest_set(input logic [N_REQ-1:0] v);
		logic [N_REQ-1:0] oh;
		logic found;
		oh = '0;
		found = 1'b0;
		for (int i = 0; i < N_REQ; i++) begin
			if (v[i] && !found) begin
				oh[i] = 1'b1;
				found = 1'b1;
			end
		end
		return oh;
	endfunction

	// One-hot to index
	function automatic master_id_t onehot2id(input logic [N_REQ-1:0] oh);
		master_id_t id;
		id = '0;
		for (int i = 0; i < N_REQ; i++) begin
			if (oh[i]) begin
				id = id | master_id_t'(i);
			end
		end
		return id;
	endfunction

	// Bit i set when some bit below i was the last grant
	always_comb begin
		above = '0;
		for (int i = 1; i < N_REQ; i++) begin
			above[i] = above[i-1] | last_gnt_q[i-1];
		end
	end

	assign masked_req = req_i & above;
	// First requester above the last one wins, else wrap to the lowest index
	assign pick = (|masked_req) ? lowest_set(masked_req) : lowest_set(req_i);

	// Re-arbitrate when free or when the owner has dropped its request
	// A waiting requester can take over on the same edge the owner is released
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q <= '0;
			last_gnt_q <= '0;
			gnt_id_q <= '0;
		end else if (gnt_q == '0 || (gnt_q & req_i) == '0) begin
			gnt_q <= pick;
			if (|pick) begin
				last_gnt_q <= pick;
				gnt_id_q <= onehot2id(pick);
			end
		end
	end

	assign gnt_o = |gnt_q;
	assign gnt_id_o = gnt_id_q;

endmodule

// ==== src/wb_master_port.sv ====
// Per-master cycle tracker of the crossbar, decodes the target slave and returns its response
`include "wb_xbar_params.svh"

module wb_master_port import wb_xbar_pkg::*; #(
	parameter master_id_t MASTER_ID = '0
) (
	input logic clk,
	input logic rstn,
	input logic cyc_i,
	input logic stb_i,
	input wb_adr_t adr_i,
	input logic [`WB_N_SLAVES:0] gnt_i,
	input master_id_t gnt_id_i [`WB_N_SLAVES+1],
	input logic [`WB_N_SLAVES:0] s_ack_i,
	input logic [`WB_N_SLAVES:0] s_err_i,
	input wb_dat_t s_dat_i [`WB_N_SLAVES+1],
	output target_id_t target_o,
	output logic valid_o,
	output logic ack_o,
	output logic err_o,
	output wb_dat_t dat_o
);

	localparam int N_TGT = `WB_N_SLAVES + 1;

	// Tracker state, low while idle and high while a cycle owns a target
	logic busy_q;
	target_id_t target_q;

	// Windows are tried in slave order and the first hit wins
	function automatic target_id_t addr2target(input wb_adr_t adr);
		if (adr >= `WB_S0_BASE && adr <= `WB_S0_LIMIT) begin
			return target_id_t'(0);
		end
		if (adr >= `WB_S1_BASE && adr <= `WB_S1_LIMIT) begin
			return target_id_t'(1);
		end
		if (adr >= `WB_S2_BASE && adr <= `WB_S2_LIMIT) begin
			return target_id_t'(2);
		end
		if (adr >= `WB_S3_BASE && adr <= `WB_S3_LIMIT) begin
			return target_id_t'(3);
		end
		// Nothing matched, so the error responder answers
		return TARGET_ERR;
	endfunction

	// Capture the target at the start of a cycle
	// Release it on the edge that sees the response, or when the master abandons the cycle
	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			target_q <= TARGET_NONE;
		end else if (!busy_q) begin
			if (cyc_i && stb_i) begin
				busy_q <= 1'b1;
				target_q <= addr2target(adr_i);
			end
		end else if (ack_o || err_o || !cyc_i) begin
			busy_q <= 1'b0;
			target_q <= TARGET_NONE;
		end
	end

	// Response path is combinational
	// Only the target whose grant belongs to this master is passed back
	always_comb begin
		ack_o = 1'b0;
		err_o = 1'b0;
		dat_o = '0;
		for (int t = 0; t < N_TGT; t++) begin
			if (busy_q && target_q == target_id_t'(t) && gnt_i[t] && gnt_id_i[t] == MASTER_ID) begin
				ack_o = s_ack_i[t];
				err_o = s_err_i[t];
				dat_o = s_dat_i[t];
			end
		end
	end

	// Request towards the arbiters
	assign target_o = target_q;
	assign valid_o = busy_q;

endmodule

// ==== src/wb_xbar_pkg.sv ====
// Bus and index types shared by the crossbar RTL and its testbench, imported by wildcard
`include "wb_xbar_params.svh"

package wb_xbar_pkg;

	// One bus word of address and of data
	typedef logic [`WB_ADDR_WIDTH-1:0] wb_adr_t;
	typedef logic [`WB_DATA_WIDTH-1:0] wb_dat_t;

	// One select bit per data byte
	typedef logic [(`WB_DATA_WIDTH/8)-1:0] wb_sel_t;

	// Index of a master port
	typedef logic [$clog2(`WB_N_MASTERS)-1:0] master_id_t;

	// Index of a target, slaves first and then the error responder
	typedef logic [$clog2(`WB_N_SLAVES+1)-1:0] target_id_t;

	// Decode-error responder slot
	localparam target_id_t TARGET_ERR = target_id_t'(`WB_N_SLAVES);

	// Idle value of a master's target register, outside the target range
	localparam target_id_t TARGET_NONE = '1;

endpackage

// ==== include/wb_xbar_params.svh ====
// Widths, port counts and slave address windows of the crossbar, included by the package and RTL
`ifndef WB_XBAR_PARAMS_SVH
`define WB_XBAR_PARAMS_SVH

// Bus widths
`define WB_ADDR_WIDTH 32
`define WB_DATA_WIDTH 32

// Port counts
// The decode-error responder sits after the last slave as an extra target
`define WB_N_MASTERS 3
`define WB_N_SLAVES 4

// Slave 0 window, inclusive bounds
`define WB_S0_BASE 32'h0000_0000
`define WB_S0_LIMIT 32'h0000_0FFF

// Slave 1 window
`define WB_S1_BASE 32'h0000_1000
`define WB_S1_LIMIT 32'h0000_1FFF

// Slave 2 window
`define WB_S2_BASE 32'h0001_0000
`define WB_S2_LIMIT 32'h0001_0FFF

// Slave 3 window, small register block high in the map
`define WB_S3_BASE 32'h8000_0000
`define WB_S3_LIMIT 32'h8000_00FF

`endif
